// ==== flist.f ====
logic/sd_host_pkg.sv
logic/sd_host_regs.sv
logic/sd_clk_divider.sv
logic/sd_cmd_shifter.sv
logic/sd_cmd_crc7.sv
logic/sd_cmd_line.sv
logic/sd_host_top.sv
test/sd_host_sva.sv
test/sd_host_tb.sv

// ==== test/sd_host_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_host_tb;

    logic                              aclk_i;
    logic                              reset_i;
    logic [sd_host_pkg::ADDR_W-1:0]    paddr_i;
    logic                              psel_i;
    logic                              penable_i;
    logic                              pwrite_i;
    logic [sd_host_pkg::DATA_W-1:0]    pwdata_i;
    logic [sd_host_pkg::DATA_W-1:0]    prdata_o;
    logic                              pready_o;
    logic                              sd_clk_o;
    logic                              sd_cmd_o;
    logic                              sd_cmd_oe_o;
    logic                              interrupt_o;

    int checks = 0;
    int errors = 0;
    integer seed;

    // Frames captured from the command line in arrival order
    logic [47:0] frames[$];
    int frame_lens[$];
    logic [47:0] cur_frame = '0;
    int cur_bits = 0;
    logic sd_clk_prev = 1'b0;
    logic oe_prev = 1'b0;

    sd_host_top dut_i (
        .aclk_i      (aclk_i),
        .reset_i     (reset_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .sd_clk_o    (sd_clk_o),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o),
        .interrupt_o (interrupt_o)
    );

    initial begin
        aclk_i = 1'b0;
        forever #4 aclk_i = !aclk_i;
    end

    // Hard stop in case a wait loop misbehaves
    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("Checks failed");
        $finish;
    end

    // Rising sd_clk seen at the aclk falling edge where the line is stable
    always @(negedge aclk_i) begin
        if (sd_cmd_oe_o && sd_clk_o && !sd_clk_prev) begin
            cur_frame = {cur_frame[46:0], sd_cmd_o};
            cur_bits = cur_bits + 1;
        end
        if (oe_prev && !sd_cmd_oe_o) begin
            frames.push_back(cur_frame);
            frame_lens.push_back(cur_bits);
            cur_frame = '0;
            cur_bits = 0;
        end
        sd_clk_prev = sd_clk_o;
        oe_prev = sd_cmd_oe_o;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic write_reg(input logic [sd_host_pkg::ADDR_W-1:0] addr,
                             input logic [sd_host_pkg::DATA_W-1:0] data,
                             output int stall);
        int cycles;
        logic ready;
        @(negedge aclk_i);
        paddr_i = addr;
        pwrite_i = 1'b1;
        pwdata_i = data;
        psel_i = 1'b1;
        penable_i = 1'b0;
        @(negedge aclk_i);
        penable_i = 1'b1;
        cycles = 0;
        ready = 1'b0;
        while (!ready && cycles < 2000) begin
            @(posedge aclk_i);
            ready = pready_o;
            if (!ready) begin
                cycles++;
            end
        end
        if (!ready) begin
            report_timeout("pready_o on an APB write");
        end
        stall = cycles;
        @(negedge aclk_i);
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
    endtask

    task automatic read_reg(input logic [sd_host_pkg::ADDR_W-1:0] addr,
                            output logic [sd_host_pkg::DATA_W-1:0] data);
        int cycles;
        logic ready;
        @(negedge aclk_i);
        paddr_i = addr;
        pwrite_i = 1'b0;
        psel_i = 1'b1;
        penable_i = 1'b0;
        @(negedge aclk_i);
        penable_i = 1'b1;
        cycles = 0;
        ready = 1'b0;
        data = 'x;
        while (!ready && cycles < 2000) begin
            @(posedge aclk_i);
            ready = pready_o;
            data = prdata_o;
            cycles++;
        end
        if (!ready) begin
            report_timeout("pready_o on an APB read");
        end
        @(negedge aclk_i);
        psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic expect_read(input string name, input logic [sd_host_pkg::ADDR_W-1:0] addr,
                               input logic [sd_host_pkg::DATA_W-1:0] expected);
        logic [sd_host_pkg::DATA_W-1:0] data;
        read_reg(addr, data);
        check_value(name, expected, data);
    endtask

    task automatic wait_sd_rise();
        int cycles;
        logic prev;
        logic seen;
        @(negedge aclk_i);
        prev = sd_clk_o;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < 1000) begin
            @(negedge aclk_i);
            seen = sd_clk_o && !prev;
            prev = sd_clk_o;
            cycles++;
        end
        if (!seen) begin
            report_timeout("a rising edge of sd_clk_o");
        end
    endtask

    task automatic measure_period(input string name, input int divisor);
        time t0;
        time t1;
        // Let a freshly written divisor settle first
        wait_sd_rise();
        wait_sd_rise();
        t0 = $time;
        wait_sd_rise();
        t1 = $time;
        check_value(name, 2 * (divisor + 1) * 8, t1 - t0);
    endtask

    task automatic wait_frames(input int count);
        int cycles;
        cycles = 0;
        while (frames.size() < count && cycles < 5000) begin
            @(posedge aclk_i);
            cycles++;
        end
        if (frames.size() < count) begin
            report_timeout("the end of a command frame");
        end
    endtask

    // Serial CRC7 with polynomial x^7 + x^3 + 1
    function automatic logic [6:0] crc7_model(input logic [39:0] bits);
        logic [6:0] crc;
        logic fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ crc[6];
            crc = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
        return crc;
    endfunction

    function automatic logic [47:0] expected_frame(input logic [5:0] index,
                                                   input logic [31:0] arg);
        logic [39:0] payload;
        payload = {1'b0, 1'b1, index, arg};
        return {payload, crc7_model(payload), 1'b1};
    endfunction

    task automatic check_frame(input string name, input int k, input logic [5:0] index,
                               input logic [31:0] arg);
        if (k >= frames.size()) begin
            errors++;
            $display("frame %s was never seen on the command line", name);
        end else begin
            check_value({name, "_len"}, 48, frame_lens[k]);
            check_value(name, expected_frame(index, arg), frames[k]);
        end
    endtask

    initial begin
        logic [31:0] arg;
        logic [31:0] arg2;
        logic [5:0] index;
        logic [5:0] index2;
        int stall;
        int base;
        seed = 32'h4a3f_0c4e;
        reset_i = 1'b1;
        paddr_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        pwdata_i = '0;
        repeat (3) @(posedge aclk_i);
        @(negedge aclk_i);
        reset_i = 1'b0;

        check_value("reset_oe", 0, sd_cmd_oe_o);
        check_value("reset_cmd", 1, sd_cmd_o);
        check_value("reset_irq", 0, interrupt_o);
        check_value("reset_pready", 1, pready_o);
        expect_read("reset_clk_div", sd_host_pkg::REG_CLK_DIV, 32'h0);
        expect_read("reset_argument", sd_host_pkg::REG_ARGUMENT, 32'h0);
        expect_read("reset_command", sd_host_pkg::REG_COMMAND, 32'h0);
        expect_read("reset_status", sd_host_pkg::REG_STATUS, 32'h0);
        expect_read("reset_int_en", sd_host_pkg::REG_INT_EN, 32'h0);

        // CMD0 with zero argument has the known CRC7 0x4A
        check_value("crc7_cmd0", 7'h4A, crc7_model(40'h40_0000_0000));

        measure_period("sd_clk_div0", 0);

        arg = $random(seed);
        write_reg(sd_host_pkg::REG_CLK_DIV, 32'h0000_00A5, stall);
        write_reg(sd_host_pkg::REG_ARGUMENT, arg, stall);
        write_reg(sd_host_pkg::REG_INT_EN, 32'h1, stall);
        write_reg(8'h14, 32'hFFFF_FFFF, stall);
        expect_read("readback_clk_div", sd_host_pkg::REG_CLK_DIV, 32'hA5);
        expect_read("readback_argument", sd_host_pkg::REG_ARGUMENT, arg);
        expect_read("readback_int_en", sd_host_pkg::REG_INT_EN, 32'h1);
        expect_read("unmapped_14", 8'h14, 32'h0);
        expect_read("unmapped_fc", 8'hFC, 32'h0);

        write_reg(sd_host_pkg::REG_CLK_DIV, 32'h3, stall);
        measure_period("sd_clk_div3", 3);

        // Interrupt enable alternates across frames
        for (int n = 0; n < 4; n++) begin
            write_reg(sd_host_pkg::REG_INT_EN, n % 2, stall);
            index = $random(seed);
            arg = $random(seed);
            base = frames.size();
            write_reg(sd_host_pkg::REG_ARGUMENT, arg, stall);
            write_reg(sd_host_pkg::REG_COMMAND, {26'd0, index}, stall);
            wait_frames(base + 1);
            check_frame("frame", base, index, arg);
            expect_read("status_done", sd_host_pkg::REG_STATUS, 32'h1);
            check_value("irq_set", n % 2, interrupt_o);
            write_reg(sd_host_pkg::REG_STATUS, 32'h1, stall);
            expect_read("status_clear", sd_host_pkg::REG_STATUS, 32'h0);
            check_value("irq_clear", 0, interrupt_o);
        end

        // Second command issued while the first is on the line
        index = $random(seed);
        arg = $random(seed);
        index2 = $random(seed);
        arg2 = $random(seed);
        base = frames.size();
        write_reg(sd_host_pkg::REG_ARGUMENT, arg, stall);
        write_reg(sd_host_pkg::REG_COMMAND, {26'd0, index}, stall);
        check_value("bp_first_stall", 0, stall);
        expect_read("bp_inhibit", sd_host_pkg::REG_STATUS, 32'h2);
        write_reg(sd_host_pkg::REG_ARGUMENT, arg2, stall);
        check_value("bp_arg_stall", 0, stall);
        write_reg(sd_host_pkg::REG_COMMAND, {26'd0, index2}, stall);
        check_value("bp_stalled", 1, stall > 0);
        check_value("bp_frame_ended", base + 1, frames.size());
        // Done of the first frame cleared so the second frame must set it again
        write_reg(sd_host_pkg::REG_STATUS, 32'h1, stall);
        wait_frames(base + 2);
        check_frame("bp_frame1", base, index, arg);
        check_frame("bp_frame2", base + 1, index2, arg2);
        expect_read("bp_status_done", sd_host_pkg::REG_STATUS, 32'h1);
        write_reg(sd_host_pkg::REG_STATUS, 32'h1, stall);
        expect_read("bp_status_clear", sd_host_pkg::REG_STATUS, 32'h0);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut_i.sva_i.fail_count);
        if (errors == 0 && dut_i.sva_i.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/sd_host_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_host_sva (
    input wire logic                              aclk_i,
    input wire logic                              reset_i,
    input wire logic [sd_host_pkg::ADDR_W-1:0]    paddr_i,
    input wire logic                              psel_i,
    input wire logic                              penable_i,
    input wire logic                              pready_i,
    input wire logic                              sd_cmd_i,
    input wire logic                              sd_cmd_oe_i,
    input wire logic                              interrupt_i,
    input wire logic                              cmd_done_i
);

    int fail_count = 0;

    // Released line idles high
    idle_high: assert property (@(posedge aclk_i) disable iff (reset_i)
        !sd_cmd_oe_i |-> sd_cmd_i)
        else begin
            fail_count++;
            $error("sd_cmd_o low while the line is released");
        end

    // Only a command write may be held
    stall_cmd_only: assert property (@(posedge aclk_i) disable iff (reset_i)
        !pready_i |-> psel_i && penable_i && (paddr_i == sd_host_pkg::REG_COMMAND))
        else begin
            fail_count++;
            $error("pready_o low outside a command register access");
        end

    // Interrupt may rise on a released line only right after a frame
    irq_after_frame: assert property (@(posedge aclk_i) disable iff (reset_i)
        $rose(interrupt_i) && !sd_cmd_oe_i |-> $past(cmd_done_i))
        else begin
            fail_count++;
            $error("interrupt_o rose without a finished frame");
        end

endmodule

bind sd_host_top sd_host_sva sva_i (
    .aclk_i      (aclk_i),
    .reset_i     (reset_i),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pready_i    (pready_o),
    .sd_cmd_i    (sd_cmd_o),
    .sd_cmd_oe_i (sd_cmd_oe_o),
    .interrupt_i (interrupt_o),
    .cmd_done_i  (cmd_done)
);

`default_nettype wire

// ==== logic/sd_host_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_host_top (
    input  wire logic                              aclk_i,
    input  wire logic                              reset_i,
    input  wire logic [sd_host_pkg::ADDR_W-1:0]    paddr_i,
    input  wire logic                              psel_i,
    input  wire logic                              penable_i,
    input  wire logic                              pwrite_i,
    input  wire logic [sd_host_pkg::DATA_W-1:0]    pwdata_i,
    output logic [sd_host_pkg::DATA_W-1:0]         prdata_o,
    output logic                                   pready_o,
    output logic                                   sd_clk_o,
    output logic                                   sd_cmd_o,
    output logic                                   sd_cmd_oe_o,
    output logic                                   interrupt_o
);

    logic [sd_host_pkg::DIV_W-1:0] divisor;
    sd_host_pkg::cmd_req_t cmd_req;
    sd_host_pkg::cmd_phase_e phase;
    logic cmd_start;
    logic cmd_done;
    logic busy;
    logic fall_tick;
    logic payload_bit;
    logic bit_en;
    logic crc_bit;

    sd_host_regs regs_i (
        .aclk_i      (aclk_i),
        .reset_i     (reset_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .busy_i      (busy),
        .cmd_done_i  (cmd_done),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .divisor_o   (divisor),
        .cmd_req_o   (cmd_req),
        .cmd_start_o (cmd_start),
        .interrupt_o (interrupt_o)
    );

    sd_clk_divider clk_div_i (
        .aclk_i      (aclk_i),
        .reset_i     (reset_i),
        .divisor_i   (divisor),
        .sd_clk_o    (sd_clk_o),
        .fall_tick_o (fall_tick)
    );

    // Shifter and CRC run side by side on the same bits
    sd_cmd_shifter shifter_i (
        .aclk_i        (aclk_i),
        .reset_i       (reset_i),
        .fall_tick_i   (fall_tick),
        .cmd_start_i   (cmd_start),
        .cmd_req_i     (cmd_req),
        .cmd_done_i    (cmd_done),
        .phase_o       (phase),
        .payload_bit_o (payload_bit),
        .bit_en_o      (bit_en),
        .busy_o        (busy)
    );

    sd_cmd_crc7 crc7_i (
        .aclk_i        (aclk_i),
        .reset_i       (reset_i),
        .phase_i       (phase),
        .payload_bit_i (payload_bit),
        .bit_en_i      (bit_en),
        .crc_bit_o     (crc_bit)
    );

    sd_cmd_line line_i (
        .aclk_i        (aclk_i),
        .reset_i       (reset_i),
        .phase_i       (phase),
        .payload_bit_i (payload_bit),
        .crc_bit_i     (crc_bit),
        .bit_en_i      (bit_en),
        .fall_tick_i   (fall_tick),
        .sd_cmd_o      (sd_cmd_o),
        .sd_cmd_oe_o   (sd_cmd_oe_o),
        .cmd_done_o    (cmd_done)
    );

endmodule

`default_nettype wire

// ==== logic/sd_cmd_line.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_line (
    input  wire logic                   aclk_i,
    input  wire logic                   reset_i,
    input  sd_host_pkg::cmd_phase_e     phase_i,
    input  wire logic                   payload_bit_i,
    input  wire logic                   crc_bit_i,
    input  wire logic                   bit_en_i,
    input  wire logic                   fall_tick_i,
    output logic                        sd_cmd_o,
    output logic                        sd_cmd_oe_o,
    output logic                        cmd_done_o
);

    logic end_sent_q;
    logic next_bit;

    always_comb begin
        case (phase_i)
            sd_host_pkg::PH_PAYLOAD: next_bit = payload_bit_i;
            sd_host_pkg::PH_CRC:     next_bit = crc_bit_i;
            default:                 next_bit = 1'b1;
        endcase
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            cmd_done_o  <= 1'b0;
            end_sent_q  <= 1'b0;
        end else begin
            cmd_done_o <= 1'b0;
            if (end_sent_q && fall_tick_i) begin
                // End bit held for a full SD clock, release the line
                sd_cmd_o    <= 1'b1;
                sd_cmd_oe_o <= 1'b0;
                cmd_done_o  <= 1'b1;
                end_sent_q  <= 1'b0;
            end else if (bit_en_i) begin
                sd_cmd_o    <= next_bit;
                sd_cmd_oe_o <= 1'b1;
                end_sent_q  <= (phase_i == sd_host_pkg::PH_END);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sd_cmd_crc7.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_crc7 (
    input  wire logic                   aclk_i,
    input  wire logic                   reset_i,
    input  sd_host_pkg::cmd_phase_e     phase_i,
    input  wire logic                   payload_bit_i,
    input  wire logic                   bit_en_i,
    output logic                        crc_bit_o
);

    logic [sd_host_pkg::CRC_BITS-1:0] crc_q;
    logic feedback;

    assign feedback = payload_bit_i ^ crc_q[sd_host_pkg::CRC_BITS-1];
    assign crc_bit_o = crc_q[sd_host_pkg::CRC_BITS-1];

    always_ff @(posedge aclk_i) begin
        if (reset_i || phase_i == sd_host_pkg::PH_IDLE) begin
            crc_q <= '0;
        end else if (bit_en_i) begin
            if (phase_i == sd_host_pkg::PH_PAYLOAD) begin
                crc_q <= {crc_q[sd_host_pkg::CRC_BITS-2:0], 1'b0}
                         ^ (feedback ? sd_host_pkg::CRC_POLY : '0);
            end else if (phase_i == sd_host_pkg::PH_CRC) begin
                // Shift out MSB first
                crc_q <= {crc_q[sd_host_pkg::CRC_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sd_cmd_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_shifter (
    input  wire logic                   aclk_i,
    input  wire logic                   reset_i,
    input  wire logic                   fall_tick_i,
    input  wire logic                   cmd_start_i,
    input  sd_host_pkg::cmd_req_t       cmd_req_i,
    input  wire logic                   cmd_done_i,
    output sd_host_pkg::cmd_phase_e     phase_o,
    output logic                        payload_bit_o,
    output logic                        bit_en_o,
    output logic                        busy_o
);

    logic [sd_host_pkg::PAYLOAD_BITS-1:0] payload_q;
    logic [sd_host_pkg::BIT_CNT_W-1:0] bit_cnt_q;

    assign bit_en_o = fall_tick_i && (phase_o != sd_host_pkg::PH_IDLE);
    assign payload_bit_o = payload_q[sd_host_pkg::PAYLOAD_BITS-1];
    assign busy_o = cmd_start_i || (phase_o != sd_host_pkg::PH_IDLE);

    // Start bit 0, direction bit 1, then index and argument
    always_ff @(posedge aclk_i) begin
        if (phase_o == sd_host_pkg::PH_IDLE && cmd_start_i) begin
            payload_q <= {1'b0, 1'b1, cmd_req_i.index, cmd_req_i.argument};
        end else if (bit_en_o) begin
            payload_q <= {payload_q[sd_host_pkg::PAYLOAD_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            phase_o   <= sd_host_pkg::PH_IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (phase_o)
                sd_host_pkg::PH_IDLE: begin
                    bit_cnt_q <= '0;
                    if (cmd_start_i) begin
                        phase_o <= sd_host_pkg::PH_PAYLOAD;
                    end
                end
                sd_host_pkg::PH_PAYLOAD: begin
                    if (bit_en_o) begin
                        if (bit_cnt_q == sd_host_pkg::PAYLOAD_BITS - 1) begin
                            bit_cnt_q <= '0;
                            phase_o   <= sd_host_pkg::PH_CRC;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                sd_host_pkg::PH_CRC: begin
                    if (bit_en_o) begin
                        if (bit_cnt_q == sd_host_pkg::CRC_BITS - 1) begin
                            bit_cnt_q <= '0;
                            phase_o   <= sd_host_pkg::PH_END;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    // End bit goes out here, line reports when done
                    if (cmd_done_i) begin
                        phase_o <= sd_host_pkg::PH_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/sd_clk_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_clk_divider (
    input  wire logic                           aclk_i,
    input  wire logic                           reset_i,
    input  wire logic [sd_host_pkg::DIV_W-1:0]  divisor_i,
    output logic                                sd_clk_o,
    output logic                                fall_tick_o
);

    logic [sd_host_pkg::DIV_W-1:0] count_q;
    logic wrap;

    // A smaller divisor written mid-count still wraps
    assign wrap = (count_q >= divisor_i);

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            count_q  <= '0;
            sd_clk_o <= 1'b0;
        end else if (wrap) begin
            count_q  <= '0;
            sd_clk_o <= !sd_clk_o;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // Last cycle of the high half
    assign fall_tick_o = wrap && sd_clk_o;

endmodule

`default_nettype wire

// ==== logic/sd_host_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_host_regs (
    input  wire logic                              aclk_i,
    input  wire logic                              reset_i,
    input  wire logic [sd_host_pkg::ADDR_W-1:0]    paddr_i,
    input  wire logic                              psel_i,
    input  wire logic                              penable_i,
    input  wire logic                              pwrite_i,
    input  wire logic [sd_host_pkg::DATA_W-1:0]    pwdata_i,
    input  wire logic                              busy_i,
    input  wire logic                              cmd_done_i,
    output logic [sd_host_pkg::DATA_W-1:0]         prdata_o,
    output logic                                   pready_o,
    output logic [sd_host_pkg::DIV_W-1:0]          divisor_o,
    output sd_host_pkg::cmd_req_t                  cmd_req_o,
    output logic                                   cmd_start_o,
    output logic                                   interrupt_o
);

    sd_host_pkg::reg_addr_e addr;
    logic access;
    logic cmd_write;
    logic write_done;
    logic int_en_q;
    logic done_q;

    assign addr = sd_host_pkg::reg_addr_e'(paddr_i);
    assign access = psel_i && penable_i;
    assign cmd_write = access && pwrite_i && (addr == sd_host_pkg::REG_COMMAND);

    // Hold a command write until the current frame is out
    assign pready_o = !(cmd_write && busy_i);
    assign write_done = access && pwrite_i && pready_o;

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            divisor_o   <= '0;
            cmd_req_o   <= '0;
            int_en_q    <= 1'b0;
            cmd_start_o <= 1'b0;
        end else begin
            cmd_start_o <= 1'b0;
            if (write_done) begin
                case (addr)
                    sd_host_pkg::REG_CLK_DIV: begin
                        divisor_o <= pwdata_i[sd_host_pkg::DIV_W-1:0];
                    end
                    sd_host_pkg::REG_ARGUMENT: begin
                        cmd_req_o.argument <= pwdata_i[sd_host_pkg::ARG_W-1:0];
                    end
                    sd_host_pkg::REG_COMMAND: begin
                        cmd_req_o.index <= pwdata_i[sd_host_pkg::CMD_INDEX_W-1:0];
                        // Start one cycle later so the shifter sees the new index
                        cmd_start_o <= 1'b1;
                    end
                    sd_host_pkg::REG_INT_EN: begin
                        int_en_q <= pwdata_i[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Command complete, set wins over a clear in the same cycle
    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            done_q <= 1'b0;
        end else if (cmd_done_i) begin
            done_q <= 1'b1;
        end else if (write_done && (addr == sd_host_pkg::REG_STATUS)
                     && pwdata_i[sd_host_pkg::STATUS_DONE_BIT]) begin
            done_q <= 1'b0;
        end
    end

    always_comb begin
        prdata_o = '0;
        case (addr)
            sd_host_pkg::REG_CLK_DIV: begin
                prdata_o[sd_host_pkg::DIV_W-1:0] = divisor_o;
            end
            sd_host_pkg::REG_ARGUMENT: begin
                prdata_o[sd_host_pkg::ARG_W-1:0] = cmd_req_o.argument;
            end
            sd_host_pkg::REG_COMMAND: begin
                prdata_o[sd_host_pkg::CMD_INDEX_W-1:0] = cmd_req_o.index;
            end
            sd_host_pkg::REG_STATUS: begin
                prdata_o[sd_host_pkg::STATUS_DONE_BIT] = done_q;
                prdata_o[sd_host_pkg::STATUS_INHIBIT_BIT] = busy_i;
            end
            sd_host_pkg::REG_INT_EN: begin
                prdata_o[0] = int_en_q;
            end
            default: begin
            end
        endcase
    end

    assign interrupt_o = done_q && int_en_q;

endmodule

`default_nettype wire

// ==== logic/sd_host_pkg.sv ====
`default_nettype none

package sd_host_pkg;

    // APB port
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // Command frame fields
    localparam int DIV_W = 8;
    localparam int CMD_INDEX_W = 6;
    localparam int ARG_W = 32;
    localparam int PAYLOAD_BITS = 2 + CMD_INDEX_W + ARG_W;
    localparam int CRC_BITS = 7;
    localparam int BIT_CNT_W = $clog2(PAYLOAD_BITS);

    // x^7 + x^3 + 1, leading term implied
    localparam logic [CRC_BITS-1:0] CRC_POLY = 7'h09;

    // STATUS register bits
    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_INHIBIT_BIT = 1;

    typedef enum logic [ADDR_W-1:0] {
        REG_CLK_DIV  = 8'h00,
        REG_ARGUMENT = 8'h04,
        REG_COMMAND  = 8'h08,
        REG_STATUS   = 8'h0C,
        REG_INT_EN   = 8'h10
    } reg_addr_e;

    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [ARG_W-1:0]       argument;
    } cmd_req_t;

    // Where the command line is within a frame
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_PAYLOAD,
        PH_CRC,
        PH_END
    } cmd_phase_e;

endpackage

`default_nettype wire
